/* nnInference.f */
+incdir+hdl
+incdir+verification
hdl/nnPkg.sv
hdl/activationFifo.sv
hdl/denseNeuron.sv
hdl/hiddenLayer.sv
hdl/outputNeuron.sv
hdl/nnInference.sv
verification/nnInference_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the nnInference testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal \
	--top-module nnInference_tb -Mdir "$OBJ_DIR" -o nnInference_sim \
	-f nnInference.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ_DIR/nnInference_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qF "All tests passed!" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* verification/nnModel.svh */
`ifndef NN_MODEL_SVH
`define NN_MODEL_SVH

// Reference arithmetic for the scoreboard, Q8.8 with 16-bit wrap

function automatic nnPkg::activation_t qMul(input nnPkg::activation_t a,
		input nnPkg::activation_t b);
	longint wide;
	wide = longint'(a) * longint'(b);
	return nnPkg::activation_t'(wide >>> `NN_FRAC_BITS);   // Keep low 16 bits
endfunction

function automatic nnPkg::activation_t preActivation(input int n,
		input nnPkg::featureVec_t f);
	nnPkg::activation_t sum;
	sum = '0;
	for (int i = 0; i < `NN_INPUTS; i++)
		sum = sum + qMul(f[i], nnPkg::hiddenWeights[n][i]);
	return sum + nnPkg::hiddenBias[n];   // Bias last
endfunction

// Hidden neurons that the ReLU forces to zero
function automatic int clampCount(input nnPkg::featureVec_t f);
	int clamps;
	clamps = 0;
	for (int n = 0; n < `NN_HIDDEN; n++)
		if (preActivation(n, f) < 0)
			clamps++;
	return clamps;
endfunction

function automatic nnPkg::activation_t modelScore(input nnPkg::featureVec_t f);
	nnPkg::activation_t acc;
	nnPkg::activation_t hidden;
	acc = '0;
	for (int n = 0; n < `NN_HIDDEN; n++)
	begin
		hidden = preActivation(n, f);
		if (hidden < 0)
			hidden = '0;   // ReLU
		acc = acc + qMul(hidden, nnPkg::outputWeights[n]);
	end
	return acc + nnPkg::outputBias;   // Score has no ReLU
endfunction

`endif

/* verification/nnInference_tb.sv */
`default_nettype none

`include "nn_settings.svh"

module nnInference_tb;

	localparam int CLK_PERIOD = 100;
	localparam int PLANNED_FRAMES = 47;
	localparam int WATCHDOG_CYCLES = PLANNED_FRAMES * (`NN_HIDDEN + 10) + 300;

	logic clk;
	logic reset;
	logic featureValid;
	nnPkg::featureVec_t features;
	logic inputFull;
	logic resultValid;
	nnPkg::activation_t result;

	nnPkg::activation_t expQ [$];   // Scores still owed by the DUT
	nnPkg::activation_t expected;
	nnPkg::featureVec_t frame;
	int errorCount = 0;
	int testErrors = 0;
	int passCount = 0;
	int failCount = 0;
	int acceptCount = 0;
	int resultCount = 0;
	logic sawFull = 1'b0;

	`include "nnModel.svh"

	nnInference u_dut (
		.clk(clk),
		.reset(reset),
		.featureValid(featureValid),
		.features(features),
		.inputFull(inputFull),
		.resultValid(resultValid),
		.result(result)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic checkTrue(input logic cond, input string msg);
		assert (cond)
		else
		begin
			$display("%s", msg);
			errorCount++;
		end
	endtask

	task automatic finishTest(input string name);
		if (errorCount == testErrors)
		begin
			passCount++;
			$display("PASS %s", name);
		end
		else
		begin
			failCount++;
			$display("FAIL %s", name);
		end
		testErrors = errorCount;
	endtask

	task automatic driveFrame(input nnPkg::featureVec_t f);
		@(posedge clk);
		featureValid <= 1'b1;
		features <= f;
	endtask

	task automatic idleInputs();
		@(posedge clk);
		featureValid <= 1'b0;
	endtask

	task automatic drainResults(input string name);
		int waited;
		waited = 0;
		do
		begin
			@(negedge clk);
			waited++;
		end
		while (expQ.size() != 0 && waited < 8 * (`NN_HIDDEN + 10));
		checkTrue(expQ.size() == 0,
			$sformatf("%s: %0d results never arrived", name, expQ.size()));
	endtask

	function automatic nnPkg::featureVec_t randomFrame();
		nnPkg::featureVec_t f;
		foreach (f[i])
			f[i] = nnPkg::activation_t'(int'($urandom % 2048) - 1024);   // Within +/-4.0
		return f;
	endfunction

	//////////////////////////////////////////////////
	// Scoreboard
	//////////////////////////////////////////////////
	always @(posedge clk)
	begin
		if (reset)
			expQ.delete();   // Frames in flight are lost
		else
		begin
			sawFull = sawFull | inputFull;
			if (resultValid)
			begin
				resultCount++;
				checkTrue(expQ.size() != 0, "A result appeared with no frame pending");
				if (expQ.size() != 0)
				begin
					expected = expQ.pop_front();
					assert (result == expected)
					else
					begin
						$display("[ERROR] %0t result expected %0d actual %0d",
							$time, expected, result);
						errorCount++;
					end
				end
			end
			if (featureValid && !inputFull)
			begin
				expQ.push_back(modelScore(features));
				acceptCount++;
			end
		end
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Test failures found");
		$finish;
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////
	initial
	begin
		int a0;
		int r0;
		int clamps;
		void'($urandom(32'h70d4_43b5));
		clk = 1'b0;
		reset = 1'b1;
		featureValid = 1'b0;
		features = '{default: '0};
		repeat (8) @(posedge clk);
		reset <= 1'b0;

		@(negedge clk);
		checkTrue(!resultValid && !inputFull, "resultValid or inputFull high after reset");
		r0 = resultCount;
		repeat (20) @(negedge clk);
		checkTrue(resultCount == r0, "A result appeared while the engine was idle");
		finishTest("idle after reset");

		frame = '{default: '0};   // Bias-only score
		driveFrame(frame);
		idleInputs();
		drainResults("zero frame");
		finishTest("zero frame");

		clamps = 0;
		for (int k = 0; k < 3; k++)
		begin
			for (int i = 0; i < `NN_INPUTS; i++)
				frame[i] = (k == 0) ? 16'sd256 : (k == 1) ? -16'sd256 :
					((i % 2) ? -16'sd512 : 16'sd512);
			clamps += clampCount(frame);
			driveFrame(frame);
			idleInputs();
			drainResults("directed frames");
		end
		checkTrue(clamps > 0, "The directed frames never drove a hidden sum negative");
		finishTest("directed frames with ReLU clamp");

		for (int k = 0; k < 20; k++)
			driveFrame(randomFrame());
		idleInputs();
		drainResults("random burst");
		finishTest("random burst in order");

		@(negedge clk);
		a0 = acceptCount;
		r0 = resultCount;
		sawFull = 1'b0;
		for (int k = 0; k < 12; k++)
			driveFrame(randomFrame());
		idleInputs();
		drainResults("overflow burst");
		checkTrue(resultCount - r0 == acceptCount - a0,
			"Result count differs from accepted frames");
		checkTrue(sawFull, "inputFull never went high during the burst");
		checkTrue(acceptCount - a0 < 12, "No strobe was dropped while the input FIFO was full");
		finishTest("drops while full");

		for (int k = 0; k < 10; k++)
			driveFrame(randomFrame());
		idleInputs();
		reset <= 1'b1;   // Both FIFOs and the neurons still hold frames
		@(negedge clk);
		checkTrue(inputFull, "The input FIFO was not full when the reset was asserted");
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		repeat (20)
		begin
			@(negedge clk);
			checkTrue(!resultValid && !inputFull, "Output activity after the mid-stream reset");
		end
		r0 = resultCount;
		driveFrame(randomFrame());
		idleInputs();
		drainResults("after reset");
		checkTrue(resultCount == r0 + 1, "Frame after reset did not give exactly one result");
		finishTest("mid-stream reset");

		$display("Tests %0d, passed %0d, failed %0d, check errors %0d",
			passCount + failCount, passCount, failCount, errorCount);
		if (errorCount == 0 && failCount == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/nnInference.sv */
`default_nettype none

`include "nn_settings.svh"

module nnInference (
	input wire logic clk,
	input wire logic reset,
	input wire logic featureValid,
	input wire nnPkg::featureVec_t features,
	output logic inputFull,
	output logic resultValid,
	output nnPkg::activation_t result
);

	logic inEmpty;
	logic inPop;
	nnPkg::featureVec_t inHead;

	logic hidPush;
	nnPkg::hiddenVec_t hidData;
	logic [`NN_COUNT_WIDTH-1:0] hidCount;
	logic hidEmpty;
	logic hidPop;
	nnPkg::hiddenVec_t hidHead;

	//////////////////////////////////////////////////
	// Input side
	//////////////////////////////////////////////////
	activationFifo #(
		.payload_t(nnPkg::featureVec_t)
	) u_inFifo (
		.clk(clk),
		.reset(reset),
		.push(featureValid),   // Dropped while full
		.pushData(features),
		.pop(inPop),
		.popData(inHead),
		.full(inputFull),
		.empty(inEmpty),
		.count()
	);

	hiddenLayer u_hiddenLayer (
		.clk(clk),
		.reset(reset),
		.inEmpty(inEmpty),
		.inHead(inHead),
		.inPop(inPop),
		.hidCount(hidCount),
		.hidPush(hidPush),
		.hidData(hidData)
	);

	//////////////////////////////////////////////////
	// Output side
	//////////////////////////////////////////////////
	// Credit check keeps this FIFO from ever filling past depth
	activationFifo #(
		.payload_t(nnPkg::hiddenVec_t)
	) u_hidFifo (
		.clk(clk),
		.reset(reset),
		.push(hidPush),
		.pushData(hidData),
		.pop(hidPop),
		.popData(hidHead),
		.full(),
		.empty(hidEmpty),
		.count(hidCount)
	);

	outputNeuron u_outputNeuron (
		.clk(clk),
		.reset(reset),
		.hidEmpty(hidEmpty),
		.hidHead(hidHead),
		.hidPop(hidPop),
		.resultValid(resultValid),
		.result(result)
	);

endmodule

`default_nettype wire

/* hdl/outputNeuron.sv */
`default_nettype none

`include "nn_settings.svh"

module outputNeuron (
	input wire logic clk,
	input wire logic reset,
	input wire logic hidEmpty,
	input wire nnPkg::hiddenVec_t hidHead,
	output logic hidPop,
	output logic resultValid,
	output nnPkg::activation_t result
);

	localparam int IDX_W = $clog2(`NN_HIDDEN);

	typedef enum logic [1:0] {
		IDLE,
		ACCUM,
		BIAS
	} state_t;

	state_t state;
	nnPkg::hiddenVec_t hidVec;
	logic [IDX_W-1:0] idx;
	nnPkg::activation_t acc;

	assign hidPop = !hidEmpty && (state == IDLE);

	//////////////////////////////////////////////////
	// Sequencer
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= IDLE;
			idx <= '0;
			resultValid <= 1'b0;
		end
		else
		begin
			resultValid <= 1'b0;
			case (state)
				IDLE:
				begin
					if (hidPop)
					begin
						state <= ACCUM;
						idx <= '0;
					end
				end
				ACCUM:
				begin
					if (idx == IDX_W'(`NN_HIDDEN - 1))
						state <= BIAS;
					idx <= idx + 1'b1;
				end
				BIAS:
				begin
					state <= IDLE;
					resultValid <= 1'b1;   // Score ready next cycle
				end
				default: state <= IDLE;
			endcase
		end
	end

	// MAC datapath, one activation per cycle
	always_ff @(posedge clk)
	begin
		if (hidPop)
		begin
			hidVec <= hidHead;
			acc <= '0;
		end
		else if (state == ACCUM)
			acc <= acc + nnPkg::fixMul(hidVec[idx], nnPkg::outputWeights[idx]);
		if (state == BIAS)
			result <= acc + nnPkg::outputBias;   // No ReLU on the score
	end

endmodule

`default_nettype wire

/* hdl/hiddenLayer.sv */
`default_nettype none

`include "nn_settings.svh"

module hiddenLayer (
	input wire logic clk,
	input wire logic reset,
	input wire logic inEmpty,
	input wire nnPkg::featureVec_t inHead,
	output logic inPop,
	input wire logic [`NN_COUNT_WIDTH-1:0] hidCount,
	output logic hidPush,
	output nnPkg::hiddenVec_t hidData
);

	logic [`NN_COUNT_WIDTH-1:0] inFlight;   // Frames inside the neurons
	logic [`NN_COUNT_WIDTH:0] committed;
	logic [`NN_HIDDEN-1:0] neuronValid;

	//////////////////////////////////////////////////
	// Credit check
	//////////////////////////////////////////////////
	// Every frame in flight already owns a slot in the hidden FIFO
	assign committed = hidCount + inFlight;
	assign inPop = !inEmpty && (committed < `NN_FIFO_DEPTH);

	assign hidPush = &neuronValid;   // All neurons run in lockstep

	always_ff @(posedge clk)
	begin
		if (reset)
			inFlight <= '0;
		else
		begin
			case ({inPop, hidPush})
				2'b10: inFlight <= inFlight + 1'b1;
				2'b01: inFlight <= inFlight - 1'b1;
				default: inFlight <= inFlight;   // Both or neither
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Neuron array
	//////////////////////////////////////////////////
	generate
		for (genvar n = 0; n < `NN_HIDDEN; n++)
		begin : g_neuron
			denseNeuron #(
				.NEURON(n)
			) u_neuron (
				.clk(clk),
				.reset(reset),
				.inValid(inPop),
				.inputs(inHead),   // Same frame to every neuron
				.outValid(neuronValid[n]),
				.activation(hidData[n])
			);
		end
	endgenerate

endmodule

`default_nettype wire

/* hdl/denseNeuron.sv */
`default_nettype none

`include "nn_settings.svh"

module denseNeuron #(
	parameter int NEURON = 0
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic inValid,
	input wire nnPkg::featureVec_t inputs,
	output logic outValid,
	output nnPkg::activation_t activation
);

	nnPkg::featureVec_t inReg;
	nnPkg::activation_t weightedSum;
	nnPkg::activation_t sumReg;
	logic inValidQ;
	logic sumValid;

	// Products and bias, wrapping in 16 bits
	always_comb
	begin
		weightedSum = '0;
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			weightedSum = weightedSum +
				nnPkg::fixMul(inReg[i], nnPkg::hiddenWeights[NEURON][i]);
		end
		weightedSum = weightedSum + nnPkg::hiddenBias[NEURON];   // Bias last
	end

	//////////////////////////////////////////////////
	// Three-stage pipeline
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inValidQ <= 1'b0;
			sumValid <= 1'b0;
			outValid <= 1'b0;
		end
		else
		begin
			inValidQ <= inValid;
			sumValid <= inValidQ;
			outValid <= sumValid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (inValid)
			inReg <= inputs;
		if (inValidQ)
			sumReg <= weightedSum;
		if (sumValid)
			activation <= sumReg[`NN_DATA_WIDTH-1] ? '0 : sumReg;   // ReLU
	end

endmodule

`default_nettype wire

/* hdl/activationFifo.sv */
`default_nettype none

`include "nn_settings.svh"

module activationFifo #(
	parameter type payload_t = logic [`NN_DATA_WIDTH-1:0]
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic push,
	input wire payload_t pushData,
	input wire logic pop,
	output payload_t popData,
	output logic full,
	output logic empty,
	output logic [`NN_COUNT_WIDTH-1:0] count
);

	localparam int PTR_W = $clog2(`NN_FIFO_DEPTH);

	payload_t mem [`NN_FIFO_DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic doPush;
	logic doPop;

	assign doPush = push && !full;   // Dropped when full
	assign doPop = pop && !empty;

	assign full = (count == `NN_COUNT_WIDTH'(`NN_FIFO_DEPTH));
	assign empty = (count == '0);
	assign popData = mem[rdPtr];   // Head visible before pop

	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

	//////////////////////////////////////////////////
	// Pointers and occupancy
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;   // Wraps at depth
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/nnPkg.sv */
`default_nettype none

`include "nn_settings.svh"

package nnPkg;

	typedef logic signed [`NN_DATA_WIDTH-1:0] activation_t;   // Q8.8
	typedef activation_t featureVec_t [`NN_INPUTS];
	typedef activation_t hiddenVec_t [`NN_HIDDEN];

	//////////////////////////////////////////////////
	// Fixed weights, all within +/-0.5
	//////////////////////////////////////////////////
	localparam activation_t hiddenWeights [`NN_HIDDEN][`NN_INPUTS] = '{
		'{ 16'sd31, -16'sd83, 16'sd16, -16'sd64, 16'sd1, 16'sd116, -16'sd34, 16'sd66,
		   -16'sd111, 16'sd122, -16'sd72, -16'sd3, 16'sd64, 16'sd54, 16'sd112 },
		'{ -16'sd45, 16'sd27, 16'sd90, -16'sd12, -16'sd101, 16'sd8, 16'sd77, -16'sd58,
		   16'sd39, -16'sd120, 16'sd14, 16'sd95, -16'sd26, 16'sd50, -16'sd7 },
		'{ 16'sd103, -16'sd19, -16'sd66, 16'sd41, 16'sd5, -16'sd88, 16'sd24, 16'sd117,
		   -16'sd40, 16'sd12, 16'sd60, -16'sd97, 16'sd33, -16'sd5, 16'sd71 },
		'{ -16'sd9, 16'sd58, -16'sd125, 16'sd84, 16'sd36, -16'sd47, -16'sd78, 16'sd2,
		   16'sd99, 16'sd21, -16'sd63, 16'sd44, -16'sd110, 16'sd87, 16'sd18 }
	};

	localparam activation_t hiddenBias [`NN_HIDDEN] = '{
		16'sd40, -16'sd25, 16'sd12, -16'sd60
	};

	localparam activation_t outputWeights [`NN_HIDDEN] = '{
		16'sd96, -16'sd70, 16'sd110, 16'sd55
	};

	localparam activation_t outputBias = -16'sd18;

	// Full product, rescaled to Q8.8 and truncated
	function automatic activation_t fixMul(activation_t a, activation_t b);
		logic signed [2*`NN_DATA_WIDTH-1:0] product;
		product = a * b;
		fixMul = activation_t'(product >>> `NN_FRAC_BITS);
	endfunction

endpackage

`default_nettype wire

/* hdl/nn_settings.svh */
`ifndef NN_SETTINGS_SVH
`define NN_SETTINGS_SVH

//////////////////////////////////////////////////
// Network shape
//////////////////////////////////////////////////
`define NN_INPUTS 15       // Features per frame
`define NN_HIDDEN 4        // Hidden neurons

//////////////////////////////////////////////////
// Number format and buffering
//////////////////////////////////////////////////
`define NN_DATA_WIDTH 16   // Q8.8 word
`define NN_FRAC_BITS 8
`define NN_FIFO_DEPTH 4    // Power of two

// Occupancy counter must hold the value NN_FIFO_DEPTH itself
`define NN_COUNT_WIDTH ($clog2(`NN_FIFO_DEPTH) + 1)

`endif
